/* src.f */
hw/axi_dw_cfg_pkg.sv
hw/axi_dw_chan_pkg.sv
hw/axi_dw_addr_conv.sv
hw/axi_dw_w_splitter.sv
hw/axi_dw_r_packer.sv
hw/axi_downsizer.sv
verification/tb_clk_gen.sv
verification/tb_axi_downsizer.sv

/* Makefile */
# Verilator build and run for the AXI downsizer testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_downsizer
BUILD_DIR ?= build
VFLAGS    ?= --assert --timescale 1ns/1ps

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f src.f

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* verification/tb_axi_downsizer.sv */
// Testbench for the AXI downsizer with a wide master model, a narrow slave model and checks
`timescale 1ns/1ps

module tb_axi_downsizer;

    localparam int unsigned ratio           = axi_dw_cfg_pkg::ratio;
    localparam int unsigned reset_cycles    = 8;
    localparam int unsigned cycles_per_beat = 20;

    typedef enum { kind_write, kind_read, kind_resp } kind_t;

    // One table row
    typedef struct {
        string                                 name;
        kind_t                                 kind;
        logic [axi_dw_cfg_pkg::id_width-1:0]   id;
        logic [axi_dw_cfg_pkg::addr_width-1:0] addr;
        // Wide beats minus one, or B beats minus one
        logic [7:0]                            len;
        logic [axi_dw_cfg_pkg::user_width-1:0] user;
        // Four 2-bit response codes, rotated per wide beat
        logic [7:0]                            resp_pat;
        // Random ready stalls on the ports under test
        bit                                    stall;
    } test_t;

    test_t tests[$];
    string cur_test;
    int    err_count;
    int    fail_tests;

    logic clk;
    logic rst_n;

    axi_dw_chan_pkg::addr_chan_t slv_aw, slv_ar, mst_aw, mst_ar;
    axi_dw_chan_pkg::wide_w_t    slv_w;
    axi_dw_chan_pkg::narrow_w_t  mst_w;
    axi_dw_chan_pkg::wide_r_t    slv_r;
    axi_dw_chan_pkg::narrow_r_t  mst_r;
    axi_dw_chan_pkg::b_chan_t    slv_b, mst_b;
    logic slv_aw_valid, slv_aw_ready, mst_aw_valid, mst_aw_ready;
    logic slv_ar_valid, slv_ar_ready, mst_ar_valid, mst_ar_ready;
    logic slv_w_valid, slv_w_ready, mst_w_valid, mst_w_ready;
    logic slv_r_valid, slv_r_ready, mst_r_valid, mst_r_ready;
    logic slv_b_valid, slv_b_ready, mst_b_valid, mst_b_ready;

    tb_clk_gen u_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    axi_downsizer UUT (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .slv_aw_i       (slv_aw),
        .slv_aw_valid_i (slv_aw_valid),
        .slv_aw_ready_o (slv_aw_ready),
        .slv_w_i        (slv_w),
        .slv_w_valid_i  (slv_w_valid),
        .slv_w_ready_o  (slv_w_ready),
        .slv_b_o        (slv_b),
        .slv_b_valid_o  (slv_b_valid),
        .slv_b_ready_i  (slv_b_ready),
        .slv_ar_i       (slv_ar),
        .slv_ar_valid_i (slv_ar_valid),
        .slv_ar_ready_o (slv_ar_ready),
        .slv_r_o        (slv_r),
        .slv_r_valid_o  (slv_r_valid),
        .slv_r_ready_i  (slv_r_ready),
        .mst_aw_o       (mst_aw),
        .mst_aw_valid_o (mst_aw_valid),
        .mst_aw_ready_i (mst_aw_ready),
        .mst_w_o        (mst_w),
        .mst_w_valid_o  (mst_w_valid),
        .mst_w_ready_i  (mst_w_ready),
        .mst_b_i        (mst_b),
        .mst_b_valid_i  (mst_b_valid),
        .mst_b_ready_o  (mst_b_ready),
        .mst_ar_o       (mst_ar),
        .mst_ar_valid_o (mst_ar_valid),
        .mst_ar_ready_i (mst_ar_ready),
        .mst_r_i        (mst_r),
        .mst_r_valid_i  (mst_r_valid),
        .mst_r_ready_o  (mst_r_ready)
    );

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_addr(input string what, input axi_dw_chan_pkg::addr_chan_t exp,
                              input axi_dw_chan_pkg::addr_chan_t act);
        if (act !== exp)
        begin
            $display("** Error: %0s: %0s expected %h actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_narrow_w(input string what, input axi_dw_chan_pkg::narrow_w_t exp,
                                  input axi_dw_chan_pkg::narrow_w_t act);
        if (act !== exp)
        begin
            $display("** Error: %0s: %0s expected %h actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_wide_r(input string what, input axi_dw_chan_pkg::wide_r_t exp,
                                input axi_dw_chan_pkg::wide_r_t act);
        if (act !== exp)
        begin
            $display("** Error: %0s: %0s expected %h actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_b(input string what, input axi_dw_chan_pkg::b_chan_t exp,
                           input axi_dw_chan_pkg::b_chan_t act);
        if (act !== exp)
        begin
            $display("** Error: %0s: %0s expected %h actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    // Valid and ready levels
    task automatic check_level(input string what, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error: %0s: %0s expected %b actual %b", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic add_test(input string name, input kind_t kind, input logic [3:0] id,
                            input logic [31:0] addr, input logic [7:0] len,
                            input logic [3:0] user, input logic [7:0] resp_pat, input bit stall);
        test_t t;
        t.name     = name;
        t.kind     = kind;
        t.id       = id;
        t.addr     = addr;
        t.len      = len;
        t.user     = user;
        t.resp_pat = resp_pat;
        t.stall    = stall;
        tests.push_back(t);
    endtask

    // Ready high about two cycles in three when stalling
    function automatic logic ready_level(input bit stall);
        return stall ? (($urandom % 3) != 0) : 1'b1;
    endfunction

    // Narrow beat i picks a code, shifted by one slot per wide beat
    function automatic logic [1:0] resp_code(input logic [7:0] pat, input int i);
        int s;
        s = (i + i / ratio) % ratio;
        return pat[2*s +: 2];
    endfunction

    function automatic int beats_of(input test_t t);
        if (t.kind == kind_resp)
        begin
            return int'(t.len) + 1;
        end
        return 1 + (int'(t.len) + 1) * ratio;
    endfunction

    task automatic watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("Timeout: test %0s did not finish within %0d cycles", cur_test, cycles);
        $display("Result: FAILED");
        $finish;
    endtask

    //////////////////////////////
    // Channel models
    //////////////////////////////

    // AW or AR request, checked against the narrow rewrite rule
    task automatic send_addr(input test_t t, input bit is_read);
        axi_dw_chan_pkg::addr_chan_t req;
        axi_dw_chan_pkg::addr_chan_t exp;
        logic done;
        req.id    = t.id;
        req.addr  = t.addr;
        req.len   = t.len;
        req.size  = 3'd4;
        req.burst = axi_dw_cfg_pkg::burst_incr;
        req.user  = t.user;
        exp       = req;
        // Four narrow beats per wide beat, 4-byte beats, word aligned
        exp.len       = 8'((int'(t.len) + 1) * 4 - 1);
        exp.size      = 3'd2;
        exp.addr[1:0] = 2'b00;
        done = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            if (is_read)
            begin
                slv_ar       = req;
                slv_ar_valid = 1'b1;
                mst_ar_ready = ready_level(t.stall);
                #1;
                check_addr("ar payload", exp, mst_ar);
                check_level("ar valid", 1'b1, mst_ar_valid);
                check_level("ar ready", mst_ar_ready, slv_ar_ready);
                done = mst_ar_ready;
            end
            else
            begin
                slv_aw       = req;
                slv_aw_valid = 1'b1;
                mst_aw_ready = ready_level(t.stall);
                #1;
                check_addr("aw payload", exp, mst_aw);
                check_level("aw valid", 1'b1, mst_aw_valid);
                check_level("aw ready", mst_aw_ready, slv_aw_ready);
                done = mst_aw_ready;
            end
        end
        @(negedge clk);
        slv_ar_valid = 1'b0;
        slv_aw_valid = 1'b0;
    endtask

    // Wide beats in, four narrow beats out per wide beat
    task automatic write_burst(input test_t t);
        axi_dw_chan_pkg::wide_w_t   beat;
        axi_dw_chan_pkg::narrow_w_t exp;
        int k;
        for (int b = 0; b <= int'(t.len); b++)
        begin
            for (int j = 0; j < ratio; j++)
            begin
                beat.data[j] = $urandom;
                beat.strb[j] = 4'($urandom);
            end
            beat.last = (b == int'(t.len));
            beat.user = t.user;
            k = 0;
            while (k < ratio)
            begin
                @(negedge clk);
                slv_w       = beat;
                slv_w_valid = 1'b1;
                mst_w_ready = ready_level(t.stall);
                #1;
                exp.data = beat.data[k];
                exp.strb = beat.strb[k];
                exp.last = beat.last && (k == ratio - 1);
                exp.user = beat.user;
                check_narrow_w("w beat", exp, mst_w);
                check_level("w valid", 1'b1, mst_w_valid);
                // Wide ready only with the fourth narrow handshake
                check_level("w ready", (k == ratio - 1) && mst_w_ready, slv_w_ready);
                if (mst_w_ready)
                begin
                    k++;
                end
            end
        end
        @(negedge clk);
        slv_w_valid = 1'b0;
        mst_w_ready = 1'b1;
    endtask

    // Narrow slave model and wide receiver run side by side
    task automatic read_burst(input test_t t);
        logic [31:0] words[$];
        int n;
        n = (int'(t.len) + 1) * ratio;
        for (int i = 0; i < n; i++)
        begin
            words.push_back($urandom);
        end
        fork
            begin
                int i;
                i = 0;
                while (i < n)
                begin
                    @(negedge clk);
                    mst_r.data  = words[i];
                    mst_r.resp  = axi_dw_cfg_pkg::resp_t'(resp_code(t.resp_pat, i));
                    mst_r.last  = (i == n - 1);
                    mst_r.id    = t.id;
                    mst_r.user  = 4'(t.user + i);
                    mst_r_valid = 1'b1;
                    #1;
                    if (mst_r_ready)
                    begin
                        i++;
                    end
                end
                @(negedge clk);
                mst_r_valid = 1'b0;
            end
            begin
                axi_dw_chan_pkg::wide_r_t exp;
                logic [1:0] mx;
                int w;
                w = 0;
                while (w <= int'(t.len))
                begin
                    @(negedge clk);
                    slv_r_ready = ready_level(t.stall);
                    #1;
                    // Narrow side waits while a full wide beat is stuck
                    check_level("r ready", !slv_r_valid || slv_r_ready, mst_r_ready);
                    if (slv_r_valid && slv_r_ready)
                    begin
                        mx = 2'b00;
                        for (int j = 0; j < ratio; j++)
                        begin
                            exp.data[j] = words[w * ratio + j];
                            if (resp_code(t.resp_pat, w * ratio + j) > mx)
                            begin
                                mx = resp_code(t.resp_pat, w * ratio + j);
                            end
                        end
                        exp.resp = axi_dw_cfg_pkg::resp_t'(mx);
                        exp.last = (w == int'(t.len));
                        exp.id   = t.id;
                        exp.user = 4'(t.user + w * ratio + ratio - 1);
                        check_wide_r($sformatf("r beat %0d", w), exp, slv_r);
                        w++;
                    end
                end
                @(negedge clk);
                slv_r_ready = 1'b1;
            end
        join
    endtask

    // B beats pass through untouched
    task automatic resp_beats(input test_t t);
        axi_dw_chan_pkg::b_chan_t beat;
        logic done;
        for (int i = 0; i <= int'(t.len); i++)
        begin
            beat.resp = axi_dw_cfg_pkg::resp_t'(resp_code(t.resp_pat, i));
            beat.id   = t.id;
            beat.user = 4'(t.user + i);
            done = 1'b0;
            while (!done)
            begin
                @(negedge clk);
                mst_b       = beat;
                mst_b_valid = 1'b1;
                slv_b_ready = ready_level(t.stall);
                #1;
                check_b("b payload", beat, slv_b);
                check_level("b valid", 1'b1, slv_b_valid);
                check_level("b ready", slv_b_ready, mst_b_ready);
                done = slv_b_ready;
            end
        end
        @(negedge clk);
        mst_b_valid = 1'b0;
        slv_b_ready = 1'b1;
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        int unsigned beats;
        int          errs_before;
        void'($urandom(53));
        err_count  = 0;
        fail_tests = 0;
        cur_test   = "reset";
        slv_aw = '0;
        slv_ar = '0;
        slv_w  = '0;
        mst_r  = '0;
        mst_b  = '0;
        slv_aw_valid = 1'b0;
        slv_ar_valid = 1'b0;
        slv_w_valid  = 1'b0;
        mst_r_valid  = 1'b0;
        mst_b_valid  = 1'b0;
        mst_aw_ready = 1'b1;
        mst_ar_ready = 1'b1;
        mst_w_ready  = 1'b1;
        slv_r_ready  = 1'b1;
        slv_b_ready  = 1'b1;

        // Name, kind, id, addr, len, user, resp codes, stall
        add_test("aw_w_single", kind_write, 4'h3, 32'h0000_1007, 8'd0, 4'h5, 8'h00, 1'b0);
        add_test("aw_w_stall", kind_write, 4'h9, 32'h0000_2010, 8'd3, 4'ha, 8'h00, 1'b1);
        add_test("aw_w_max_len", kind_write, 4'h1, 32'h0001_0003, 8'd63, 4'h2, 8'h00, 1'b1);
        add_test("ar_r_single", kind_read, 4'h2, 32'h0000_3003, 8'd0, 4'h1, 8'he4, 1'b0);
        add_test("ar_r_backpressure", kind_read, 4'h7, 32'h4000_0022, 8'd5, 4'hc, 8'h12, 1'b1);
        add_test("ar_r_okay_stream", kind_read, 4'hf, 32'h0000_00ff, 8'd15, 4'h0, 8'h00, 1'b1);
        add_test("b_single", kind_resp, 4'h4, 32'h0, 8'd0, 4'h6, 8'h02, 1'b0);
        add_test("b_stall", kind_resp, 4'hb, 32'h0, 8'd3, 4'h3, 8'hd8, 1'b1);

        beats = 0;
        foreach (tests[i])
        begin
            beats += beats_of(tests[i]);
        end
        fork
            watchdog(reset_cycles + beats * cycles_per_beat);
        join_none

        @(posedge rst_n);
        foreach (tests[i])
        begin
            cur_test    = tests[i].name;
            errs_before = err_count;
            case (tests[i].kind)
                kind_write:
                begin
                    send_addr(tests[i], 1'b0);
                    write_burst(tests[i]);
                end
                kind_read:
                begin
                    send_addr(tests[i], 1'b1);
                    read_burst(tests[i]);
                end
                default:
                begin
                    resp_beats(tests[i]);
                end
            endcase
            if (err_count == errs_before)
            begin
                $display("test %0s: ok", cur_test);
            end
            else
            begin
                $display("test %0s: %0d mismatches", cur_test, err_count - errs_before);
                fail_tests++;
            end
        end

        $display("Tests: %0d run, %0d failing, %0d mismatches", tests.size(), fail_tests,
                 err_count);
        if (err_count == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verification/tb_clk_gen.sv */
// Clock and reset source for the downsizer testbench
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic clk_o,
    output logic rst_no
);

    // 10 ns period
    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #5 clk_o = ~clk_o;
        end
    end

    // Low for 8 cycles, released away from the rising edge
    initial
    begin
        rst_no = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

/* hw/axi_downsizer.sv */
// AXI4 downsizer from a 128-bit slave port to a 32-bit master port
`timescale 1ns/1ps

module axi_downsizer
(
    input  logic                        clk_i,
    input  logic                        rst_ni,

    //////////////////////////////
    // Slave port, wide
    //////////////////////////////

    input  axi_dw_chan_pkg::addr_chan_t slv_aw_i,
    input  logic                        slv_aw_valid_i,
    output logic                        slv_aw_ready_o,

    input  axi_dw_chan_pkg::wide_w_t    slv_w_i,
    input  logic                        slv_w_valid_i,
    output logic                        slv_w_ready_o,

    output axi_dw_chan_pkg::b_chan_t    slv_b_o,
    output logic                        slv_b_valid_o,
    input  logic                        slv_b_ready_i,

    input  axi_dw_chan_pkg::addr_chan_t slv_ar_i,
    input  logic                        slv_ar_valid_i,
    output logic                        slv_ar_ready_o,

    output axi_dw_chan_pkg::wide_r_t    slv_r_o,
    output logic                        slv_r_valid_o,
    input  logic                        slv_r_ready_i,

    //////////////////////////////
    // Master port, narrow
    //////////////////////////////

    output axi_dw_chan_pkg::addr_chan_t mst_aw_o,
    output logic                        mst_aw_valid_o,
    input  logic                        mst_aw_ready_i,

    output axi_dw_chan_pkg::narrow_w_t  mst_w_o,
    output logic                        mst_w_valid_o,
    input  logic                        mst_w_ready_i,

    input  axi_dw_chan_pkg::b_chan_t    mst_b_i,
    input  logic                        mst_b_valid_i,
    output logic                        mst_b_ready_o,

    output axi_dw_chan_pkg::addr_chan_t mst_ar_o,
    output logic                        mst_ar_valid_o,
    input  logic                        mst_ar_ready_i,

    input  axi_dw_chan_pkg::narrow_r_t  mst_r_i,
    input  logic                        mst_r_valid_i,
    output logic                        mst_r_ready_o
);

    // Write address
    axi_dw_addr_conv u_aw_conv (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (slv_aw_i),
        .req_valid_i (slv_aw_valid_i),
        .req_ready_o (slv_aw_ready_o),
        .req_o       (mst_aw_o),
        .req_valid_o (mst_aw_valid_o),
        .req_ready_i (mst_aw_ready_i)
    );

    // Read address
    axi_dw_addr_conv u_ar_conv (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (slv_ar_i),
        .req_valid_i (slv_ar_valid_i),
        .req_ready_o (slv_ar_ready_o),
        .req_o       (mst_ar_o),
        .req_valid_o (mst_ar_valid_o),
        .req_ready_i (mst_ar_ready_i)
    );

    // Write data, zero latency
    axi_dw_w_splitter u_w_splitter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .wide_i         (slv_w_i),
        .wide_valid_i   (slv_w_valid_i),
        .wide_ready_o   (slv_w_ready_o),
        .narrow_o       (mst_w_o),
        .narrow_valid_o (mst_w_valid_o),
        .narrow_ready_i (mst_w_ready_i)
    );

    // Read data, one cycle latency
    axi_dw_r_packer u_r_packer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .narrow_i       (mst_r_i),
        .narrow_valid_i (mst_r_valid_i),
        .narrow_ready_o (mst_r_ready_o),
        .wide_o         (slv_r_o),
        .wide_valid_o   (slv_r_valid_o),
        .wide_ready_i   (slv_r_ready_i)
    );

    // Write response is width independent
    assign slv_b_o       = mst_b_i;
    assign slv_b_valid_o = mst_b_valid_i;
    assign mst_b_ready_o = slv_b_ready_i;

endmodule

/* hw/axi_dw_r_packer.sv */
// Read data packer that gathers ratio narrow beats into one wide beat
`timescale 1ns/1ps

module axi_dw_r_packer
(
    input  logic                       clk_i,
    input  logic                       rst_ni,

    // Narrow read beats from the master port
    input  axi_dw_chan_pkg::narrow_r_t narrow_i,
    input  logic                       narrow_valid_i,
    output logic                       narrow_ready_o,

    // Wide read beats to the slave port
    output axi_dw_chan_pkg::wide_r_t   wide_o,
    output logic                       wide_valid_o,
    input  logic                       wide_ready_i
);

    localparam int unsigned sel_w = axi_dw_cfg_pkg::word_sel_width;
    localparam int unsigned ratio = axi_dw_cfg_pkg::ratio;
    localparam int unsigned nw    = axi_dw_cfg_pkg::narrow_data_width;

    typedef enum logic {
        st_collect,
        st_dispatch
    } state_t;

    state_t state_q, state_d;

    // Next narrow word slot
    logic [sel_w-1:0] word_q;
    logic             first_word;
    logic             last_word;
    logic             take;

    // Wide beat under assembly
    logic [ratio-1:0][nw-1:0]                    data_q;
    axi_dw_cfg_pkg::resp_t                       resp_q;
    logic [axi_dw_cfg_pkg::id_width-1:0]         id_q;
    logic [axi_dw_cfg_pkg::user_width-1:0]       user_q;
    logic                                        last_q;

    assign first_word = (word_q == '0);
    assign last_word  = &word_q;

    // Accept while collecting, or while the full beat leaves
    assign narrow_ready_o = (state_q == st_collect) || wide_ready_i;
    assign take           = narrow_valid_i && narrow_ready_o;

    //////////////////////////////
    // Control
    //////////////////////////////

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            st_collect:
            begin
                // Top word completes the wide beat
                if (take && last_word)
                begin
                    state_d = st_dispatch;
                end
            end
            st_dispatch:
            begin
                if (wide_ready_i)
                begin
                    state_d = st_collect;
                end
            end
            default:
            begin
                state_d = st_collect;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q <= st_collect;
            word_q  <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (take)
            begin
                word_q <= word_q + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Payload
    //////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (take)
        begin
            data_q[word_q] <= narrow_i.data;
            // First word restarts the running maximum
            if (first_word || (narrow_i.resp > resp_q))
            begin
                resp_q <= narrow_i.resp;
            end
            // Id, user and last come from the top word
            if (last_word)
            begin
                id_q   <= narrow_i.id;
                user_q <= narrow_i.user;
                last_q <= narrow_i.last;
            end
        end
    end

    always_comb
    begin
        wide_o.data = data_q;
        wide_o.resp = resp_q;
        wide_o.last = last_q;
        wide_o.id   = id_q;
        wide_o.user = user_q;
    end

    assign wide_valid_o = (state_q == st_dispatch);

    // Offered wide beat stays, payload untouched, until taken
    a_valid_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
        wide_valid_o && !wide_ready_i |=> wide_valid_o && $stable(wide_o))
        else $error("r_packer: wide beat dropped or changed before ready");

endmodule

/* hw/axi_dw_w_splitter.sv */
// Write data splitter that cuts each wide beat into ratio narrow beats, low word first
`timescale 1ns/1ps

module axi_dw_w_splitter
(
    input  logic                       clk_i,
    input  logic                       rst_ni,

    // Wide write beats from the slave port
    input  axi_dw_chan_pkg::wide_w_t   wide_i,
    input  logic                       wide_valid_i,
    output logic                       wide_ready_o,

    // Narrow write beats to the master port
    output axi_dw_chan_pkg::narrow_w_t narrow_o,
    output logic                       narrow_valid_o,
    input  logic                       narrow_ready_i
);

    localparam int unsigned sel_w = axi_dw_cfg_pkg::word_sel_width;

    // Word currently offered on the narrow side
    logic [sel_w-1:0] word_q;
    logic             last_word;

    // Ratio is a power of two, so all ones marks the top word
    assign last_word = &word_q;

    //////////////////////////////
    // Word counter
    //////////////////////////////

    // Advances per narrow handshake, wraps by overflow
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            word_q <= '0;
        end
        else if (wide_valid_i && narrow_ready_i)
        begin
            word_q <= word_q + 1'b1;
        end
    end

    //////////////////////////////
    // Narrow beat
    //////////////////////////////

    always_comb
    begin
        narrow_o.data = wide_i.data[word_q];
        narrow_o.strb = wide_i.strb[word_q];
        narrow_o.user = wide_i.user;
        // Only the top word of the final wide beat
        narrow_o.last = wide_i.last && last_word;
    end

    assign narrow_valid_o = wide_valid_i;

    // Wide beat consumed together with its top word
    assign wide_ready_o = last_word && narrow_ready_i;

    // Sender must hold a stalled wide beat untouched
    a_wide_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
        wide_valid_i && !wide_ready_o |=> wide_valid_i && $stable(wide_i))
        else $error("w_splitter: wide beat changed while stalled");

endmodule

/* hw/axi_dw_addr_conv.sv */
// Address converter that rewrites a wide AW or AR request into a narrow-beat request
`timescale 1ns/1ps

module axi_dw_addr_conv
(
    // Clock and reset only sample the checks
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // Wide side
    input  axi_dw_chan_pkg::addr_chan_t req_i,
    input  logic                        req_valid_i,
    output logic                        req_ready_o,

    // Narrow side
    output axi_dw_chan_pkg::addr_chan_t req_o,
    output logic                        req_valid_o,
    input  logic                        req_ready_i
);

    localparam int unsigned sel_w = axi_dw_cfg_pkg::word_sel_width;
    localparam int unsigned nsize = axi_dw_cfg_pkg::narrow_size;

    //////////////////////////////
    // Request rewrite
    //////////////////////////////

    always_comb
    begin
        // Id, user and burst copied as they are
        req_o = req_i;
        // (len + 1) * ratio - 1, low bits all ones
        req_o.len = {req_i.len[7-sel_w:0], {sel_w{1'b1}}};
        // Narrow beat size
        req_o.size = 3'(nsize);
        // Align to narrow word
        req_o.addr[nsize-1:0] = '0;
    end

    // Handshake passes straight through
    assign req_valid_o = req_valid_i;
    assign req_ready_o = req_ready_i;

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Upstream must only issue INCR bursts
    a_incr_only : assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> req_i.burst == axi_dw_cfg_pkg::burst_incr)
        else $error("addr_conv: non-INCR burst requested");

    // Longer bursts would overflow the narrow len field
    a_len_limit : assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> req_i.len <= 8'(axi_dw_cfg_pkg::max_wide_len))
        else $error("addr_conv: wide burst too long");

endmodule

/* hw/axi_dw_chan_pkg.sv */
// AXI downsizer channel payloads for the wide slave port and the narrow master port
package axi_dw_chan_pkg;

    //////////////////////////////
    // Address channels
    //////////////////////////////

    // Shared by AW and AR on both ports
    typedef struct packed {
        logic [axi_dw_cfg_pkg::id_width-1:0]   id;
        logic [axi_dw_cfg_pkg::addr_width-1:0] addr;
        // Beats minus one
        logic [7:0]                            len;
        // log2 of bytes per beat
        logic [2:0]                            size;
        logic [1:0]                            burst;
        logic [axi_dw_cfg_pkg::user_width-1:0] user;
    } addr_chan_t;

    //////////////////////////////
    // Write data
    //////////////////////////////

    // Wide beat, already split into narrow words
    typedef struct packed {
        logic [axi_dw_cfg_pkg::ratio-1:0][axi_dw_cfg_pkg::narrow_data_width-1:0] data;
        logic [axi_dw_cfg_pkg::ratio-1:0][axi_dw_cfg_pkg::narrow_strb_width-1:0] strb;
        logic                                                                    last;
        logic [axi_dw_cfg_pkg::user_width-1:0]                                   user;
    } wide_w_t;

    // Narrow beat on the master port
    typedef struct packed {
        logic [axi_dw_cfg_pkg::narrow_data_width-1:0] data;
        logic [axi_dw_cfg_pkg::narrow_strb_width-1:0] strb;
        logic                                         last;
        logic [axi_dw_cfg_pkg::user_width-1:0]        user;
    } narrow_w_t;

    //////////////////////////////
    // Read data
    //////////////////////////////

    // Word 0 holds the first narrow beat
    typedef struct packed {
        logic [axi_dw_cfg_pkg::ratio-1:0][axi_dw_cfg_pkg::narrow_data_width-1:0] data;
        axi_dw_cfg_pkg::resp_t                                                   resp;
        logic                                                                    last;
        logic [axi_dw_cfg_pkg::id_width-1:0]                                     id;
        logic [axi_dw_cfg_pkg::user_width-1:0]                                   user;
    } wide_r_t;

    typedef struct packed {
        logic [axi_dw_cfg_pkg::narrow_data_width-1:0] data;
        axi_dw_cfg_pkg::resp_t                        resp;
        logic                                         last;
        logic [axi_dw_cfg_pkg::id_width-1:0]          id;
        logic [axi_dw_cfg_pkg::user_width-1:0]        user;
    } narrow_r_t;

    //////////////////////////////
    // Write response
    //////////////////////////////

    // Same on both ports
    typedef struct packed {
        axi_dw_cfg_pkg::resp_t                 resp;
        logic [axi_dw_cfg_pkg::id_width-1:0]   id;
        logic [axi_dw_cfg_pkg::user_width-1:0] user;
    } b_chan_t;

endpackage

/* hw/axi_dw_cfg_pkg.sv */
// AXI downsizer configuration with bus widths, width ratio and AXI encodings
package axi_dw_cfg_pkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////

    // Address and side-band widths, same on both ports
    localparam int unsigned addr_width = 32;
    localparam int unsigned id_width   = 4;
    localparam int unsigned user_width = 4;

    // Slave port is wide, master port is narrow
    localparam int unsigned wide_data_width   = 128;
    localparam int unsigned narrow_data_width = 32;

    // One strobe bit per byte lane
    localparam int unsigned narrow_strb_width = narrow_data_width / 8;

    //////////////////////////////
    // Width ratio
    //////////////////////////////

    // Narrow words per wide word
    localparam int unsigned ratio          = wide_data_width / narrow_data_width;
    localparam int unsigned word_sel_width = $clog2(ratio);

    // Longest wide burst whose narrow len still fits 8 bits
    localparam int unsigned max_wide_len = 256 / ratio - 1;

    // Size code of narrow beats, log2 of bytes per beat
    localparam int unsigned narrow_size = $clog2(narrow_data_width / 8);

    //////////////////////////////
    // AXI encodings
    //////////////////////////////

    // Response codes in numeric order
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_t;

    // Incrementing burst
    localparam logic [1:0] burst_incr = 2'b01;

endpackage
